// File: Bender.yml
package:
  name: jtag_debug_bridge

sources:
  - include_dirs:
      - design
    files:
      - design/jtag_pkg.sv
      - design/cdp_pkg.sv
      - design/tap_ctrl.sv
      - design/cdp_scan_chain.sv
      - design/cdp_cmd_regs.sv
      - design/memi_master.sv
      - design/jtag_debug_bridge.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/tb_jtag_debug_bridge.sv

// File: design/cdp_cmd_regs.sv
`timescale 1ns/1ps
`include "cdp_defs.svh"

module cdp_cmd_regs import cdp_pkg::*; (
    input  logic                       tck,
    input  logic                       memi_rst,
    input  logic                       cmd_valid,
    input  cdp_cmd_t                   cmd,
    input  logic                       busy,     // Transfer outstanding
    input  logic                       done,     // Transfer finished
    input  logic [`CDP_DATA_WIDTH-1:0] rdata,
    output logic                       start,    // Same cycle as cmd_valid
    output memi_req_t                  req,
    output cdp_dr_u                    cap
);

    logic [`CDP_DATA_WIDTH-1:0] select_q;        // Slave number
    logic [`CDP_ADDR_WIDTH-1:0] taddr_q;         // Target register
    logic [`CDP_DATA_WIDTH-1:0] dtr_q, dtr_d;    // Data transfer register
    logic [`CDP_DATA_WIDTH-1:0] result_q;        // Last read result
    cdp_ack_e                   ack_q;
    logic                       rd_pend;         // Outstanding transfer is a read
    logic                       dtr_cmd, dtr_wr, slave_ok;
    logic [`CDP_NR_SLAVES-1:0]  sel_dec;

    assign dtr_cmd  = cmd_valid && (cmd.op == OP_DTR);
    assign dtr_wr   = dtr_cmd && !busy;              // Dropped while busy
    assign dtr_d    = dtr_wr ? cmd.data : dtr_q;     // Forward new DTR
    assign slave_ok = (select_q < `CDP_NR_SLAVES);
    assign start    = dtr_wr && slave_ok;

    // SELECT to one-hot
    always_comb begin
        for (int i = 0; i < `CDP_NR_SLAVES; i++) begin
            sel_dec[i] = slave_ok && (select_q == i);
        end
    end

    always_comb begin
        req.sel   = sel_dec;
        req.wr    = cmd.wr;
        req.addr  = taddr_q;
        req.wdata = dtr_d;
    end

    always_ff @(posedge tck) begin
        if (cmd_valid && (cmd.op == OP_TADDR)) begin
            taddr_q <= cmd.data[`CDP_ADDR_WIDTH-1:0];
        end
        dtr_q <= dtr_d;
    end

    always_ff @(posedge tck) begin
        if (memi_rst) begin
            select_q <= '0;
            result_q <= '0;
            ack_q    <= ACK_OK;
            rd_pend  <= 1'b0;
        end else begin
            if (cmd_valid && (cmd.op == OP_SELECT)) begin
                select_q <= cmd.data;
            end
            if (start) begin
                rd_pend <= !req.wr;
            end
            if (done) begin
                ack_q <= ACK_OK;
                if (rd_pend) begin
                    result_q <= rdata;                   // Writes keep old result
                end
            end
            if (dtr_cmd && busy) begin
                ack_q <= ACK_BUSY;                       // Overrides done
            end else if (dtr_cmd && !slave_ok) begin
                ack_q <= ACK_NOSLAVE;
            end
        end
    end

    // Live BUSY while a transfer runs
    always_comb begin
        cap.cap.result = result_q;
        cap.cap.ack    = busy ? ACK_BUSY : ack_q;
    end

endmodule

// File: design/cdp_defs.svh
`ifndef CDP_DEFS_SVH
`define CDP_DEFS_SVH

// Debug access scan chain geometry
`define CDP_DR_WIDTH    36           // Result 32 plus ACK 4
`define CDP_ADDR_WIDTH  5            // Register address on the bus
`define CDP_DATA_WIDTH  32           // Bus data word
`define CDP_NR_SLAVES   4            // One select line each

// Instruction register
`define CDP_IR_WIDTH    4
`define CDP_IR_JDPACC   4'b1010      // ID chain, also the reset IR
`define CDP_IR_CDPACC   4'b1011      // Debug register access chain

// Word loaded into the JDPACC chain at Capture-DR
`define CDP_JDP_ID      36'h0_4ba0_0477

`endif

// File: design/cdp_pkg.sv
package cdp_pkg;

    `include "cdp_defs.svh"

    // Register opcode in the CDPACC update word
    typedef enum logic [2:0] {
        OP_SELECT = 3'd0,            // Slave number
        OP_TADDR  = 3'd1,            // Target register address
        OP_DTR    = 3'd2             // Data, starts a transfer
    } cdp_op_e;

    typedef enum logic [3:0] {
        ACK_OK      = 4'b0000,
        ACK_BUSY    = 4'b0001,       // Transfer still outstanding
        ACK_NOSLAVE = 4'b0010        // SELECT beyond slave count
    } cdp_ack_e;

    // CDPACC word, bit 0 leaves on TDO first
    typedef union packed {
        struct packed {
            logic [`CDP_DATA_WIDTH-1:0] data;
            cdp_op_e                    op;
            logic                       wr;     // Bit 0
        } upd;                                  // Shifted in for Update-DR
        struct packed {
            logic [`CDP_DATA_WIDTH-1:0] result;
            cdp_ack_e                   ack;    // Bits 3:0
        } cap;                                  // Loaded at Capture-DR
    } cdp_dr_u;

    typedef struct packed {
        logic [`CDP_DATA_WIDTH-1:0] data;
        cdp_op_e                    op;
        logic                       wr;
    } cdp_cmd_t;

    typedef struct packed {
        logic [`CDP_NR_SLAVES-1:0]  sel;        // One-hot slave select
        logic                       wr;         // High for write
        logic [`CDP_ADDR_WIDTH-1:0] addr;
        logic [`CDP_DATA_WIDTH-1:0] wdata;
    } memi_req_t;

endpackage

// File: design/cdp_scan_chain.sv
`timescale 1ns/1ps
`include "cdp_defs.svh"

module cdp_scan_chain import jtag_pkg::*; import cdp_pkg::*; (
    input  logic     tck,
    input  logic     memi_rst,
    input  logic     tdi,
    input  tap_ctl_t ctl,
    input  cdp_dr_u  cap,            // Result and ACK from register stage
    output logic     dr_tdo,
    output logic     cmd_valid,      // One cycle after Update-DR
    output cdp_cmd_t cmd
);

    logic [`CDP_DR_WIDTH-1:0] jdp_sr;  // JDPACC chain
    cdp_dr_u                  cdp_sr;  // CDPACC chain
    logic                     byp_sr;  // One-bit BYPASS chain
    logic                     sel_byp; // Any other instruction
    logic                     cdp_upd; // Update-DR on CDPACC

    assign sel_byp = !ctl.sel_jdpacc && !ctl.sel_cdpacc;
    assign cdp_upd = ctl.sel_cdpacc && ctl.update_dr;

    // JDPACC captures the ID word
    always_ff @(posedge tck) begin
        if (memi_rst || ctl.logic_reset) begin
            jdp_sr <= '0;
        end else if (ctl.sel_jdpacc) begin
            if (ctl.capture_dr) begin
                jdp_sr <= `CDP_JDP_ID;
            end else if (ctl.shift_dr) begin
                jdp_sr <= {tdi, jdp_sr[`CDP_DR_WIDTH-1:1]}; // Shift toward bit 0
            end
        end
    end

    // CDPACC captures result and ACK
    always_ff @(posedge tck) begin
        if (memi_rst || ctl.logic_reset) begin
            cdp_sr <= '0;
        end else if (ctl.sel_cdpacc) begin
            if (ctl.capture_dr) begin
                cdp_sr <= cap;                          // Cap view
            end else if (ctl.shift_dr) begin
                cdp_sr <= {tdi, cdp_sr[`CDP_DR_WIDTH-1:1]};
            end
        end
    end

    always_ff @(posedge tck) begin
        if (memi_rst || ctl.logic_reset) begin
            byp_sr <= 1'b0;
        end else if (sel_byp) begin
            if (ctl.capture_dr) begin
                byp_sr <= 1'b0;                         // Bypass captures zero
            end else if (ctl.shift_dr) begin
                byp_sr <= tdi;
            end
        end
    end

    // Command strobe
    always_ff @(posedge tck) begin
        if (memi_rst || ctl.logic_reset) begin
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= cdp_upd;
        end
    end

    always_ff @(posedge tck) begin
        if (cdp_upd) begin
            cmd <= cdp_sr.upd;                          // Upd view
        end
    end

    always_comb begin
        if (ctl.sel_jdpacc) begin
            dr_tdo = jdp_sr[0];
        end else if (ctl.sel_cdpacc) begin
            dr_tdo = cdp_sr[0];
        end else begin
            dr_tdo = byp_sr;
        end
    end

endmodule

// File: design/jtag_debug_bridge.sv
`timescale 1ns/1ps
`include "cdp_defs.svh"

module jtag_debug_bridge import jtag_pkg::*; import cdp_pkg::*; (
    input  logic                       tck,
    input  logic                       memi_rst,
    input  logic                       tms,
    input  logic                       tdi,
    output logic                       tdo,
    output memi_req_t                  memi_bus,     // sel addr wr wdata
    input  logic                       memi_ready,
    input  logic [`CDP_DATA_WIDTH-1:0] memi_rdata
);

    tap_ctl_t                   ctl;                 // TAP levels
    logic                       dr_tdo;
    logic                       cmd_valid;
    cdp_cmd_t                   cmd;
    cdp_dr_u                    cap;                 // Capture word
    logic                       start;
    memi_req_t                  req;
    logic                       busy;
    logic                       done;
    logic [`CDP_DATA_WIDTH-1:0] rdata;               // Sampled read data

    tap_ctrl u_tap (
        .tck      (tck),
        .memi_rst (memi_rst),
        .tms      (tms),
        .tdi      (tdi),
        .dr_tdo   (dr_tdo),
        .tdo      (tdo),
        .ctl      (ctl)
    );

    cdp_scan_chain u_scan (
        .tck       (tck),
        .memi_rst  (memi_rst),
        .tdi       (tdi),
        .ctl       (ctl),
        .cap       (cap),
        .dr_tdo    (dr_tdo),
        .cmd_valid (cmd_valid),
        .cmd       (cmd)
    );

    cdp_cmd_regs u_regs (
        .tck       (tck),
        .memi_rst  (memi_rst),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .busy      (busy),
        .done      (done),
        .rdata     (rdata),
        .start     (start),
        .req       (req),
        .cap       (cap)
    );

    memi_master u_master (
        .tck      (tck),
        .memi_rst (memi_rst),
        .start    (start),
        .req      (req),
        .ready    (memi_ready),
        .rdata_in (memi_rdata),
        .bus      (memi_bus),
        .busy     (busy),
        .done     (done),
        .rdata    (rdata)
    );

endmodule

// File: design/jtag_pkg.sv
package jtag_pkg;

    // IEEE 1149.1 controller states
    typedef enum logic [3:0] {
        TAP_RESET,                   // Test-Logic-Reset
        TAP_IDLE,                    // Run-Test/Idle
        TAP_SELECT_DR,
        TAP_CAPTURE_DR,
        TAP_SHIFT_DR,
        TAP_EXIT1_DR,
        TAP_PAUSE_DR,
        TAP_EXIT2_DR,
        TAP_UPDATE_DR,
        TAP_SELECT_IR,
        TAP_CAPTURE_IR,
        TAP_SHIFT_IR,
        TAP_EXIT1_IR,
        TAP_PAUSE_IR,
        TAP_EXIT2_IR,
        TAP_UPDATE_IR
    } tap_state_t;

    // Levels decoded from state and IR
    typedef struct packed {
        logic sel_jdpacc;            // IR holds JDPACC
        logic sel_cdpacc;            // IR holds CDPACC
        logic capture_dr;
        logic shift_dr;
        logic update_dr;
        logic logic_reset;           // In Test-Logic-Reset
    } tap_ctl_t;

endpackage

// File: design/memi_master.sv
`timescale 1ns/1ps
`include "cdp_defs.svh"

module memi_master import cdp_pkg::*; (
    input  logic                       tck,
    input  logic                       memi_rst,
    input  logic                       start,     // One-cycle request strobe
    input  memi_req_t                  req,
    input  logic                       ready,     // Slave ready
    input  logic [`CDP_DATA_WIDTH-1:0] rdata_in,
    output memi_req_t                  bus,
    output logic                       busy,
    output logic                       done,      // Cycle after completion
    output logic [`CDP_DATA_WIDTH-1:0] rdata
);

    logic active;                                 // Some sel line high
    logic held;                                   // Two-cycle minimum met
    logic complete;                               // Last bus cycle

    assign active   = |bus.sel;
    assign complete = active && held && ready;

    // Bus outputs
    always_ff @(posedge tck) begin
        if (memi_rst) begin
            bus <= '0;
        end else if (start) begin
            bus <= req;                           // sel rises next cycle
        end else if (complete) begin
            bus <= '0;                            // Idle bus is all zero
        end
    end

    // Hold count
    always_ff @(posedge tck) begin
        if (memi_rst) begin
            held <= 1'b0;
        end else if (start) begin
            held <= 1'b0;
        end else if (active) begin
            held <= !complete;                    // Set after first sel cycle
        end
    end

    // Busy from start through the done cycle
    always_ff @(posedge tck) begin
        if (memi_rst) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= complete;
            if (start) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;
            end
        end
    end

    // Sample read data in completing cycle
    always_ff @(posedge tck) begin
        if (complete) begin
            rdata <= rdata_in;
        end
    end

endmodule

// File: design/tap_ctrl.sv
`timescale 1ns/1ps
`include "cdp_defs.svh"

module tap_ctrl import jtag_pkg::*; (
    input  logic     tck,
    input  logic     memi_rst,
    input  logic     tms,
    input  logic     tdi,
    input  logic     dr_tdo,         // LSB of active data chain
    output logic     tdo,
    output tap_ctl_t ctl
);

    tap_state_t                state, state_nxt;
    logic [`CDP_IR_WIDTH-1:0]  ir_sr;          // IR shift stage
    logic [`CDP_IR_WIDTH-1:0]  ir;             // Active instruction

    always_comb begin
        case (state)
            TAP_RESET:      state_nxt = tms ? TAP_RESET     : TAP_IDLE;
            TAP_IDLE:       state_nxt = tms ? TAP_SELECT_DR : TAP_IDLE;
            TAP_SELECT_DR:  state_nxt = tms ? TAP_SELECT_IR : TAP_CAPTURE_DR;
            TAP_CAPTURE_DR: state_nxt = tms ? TAP_EXIT1_DR  : TAP_SHIFT_DR;
            TAP_SHIFT_DR:   state_nxt = tms ? TAP_EXIT1_DR  : TAP_SHIFT_DR;
            TAP_EXIT1_DR:   state_nxt = tms ? TAP_UPDATE_DR : TAP_PAUSE_DR;
            TAP_PAUSE_DR:   state_nxt = tms ? TAP_EXIT2_DR  : TAP_PAUSE_DR;
            TAP_EXIT2_DR:   state_nxt = tms ? TAP_UPDATE_DR : TAP_SHIFT_DR;
            TAP_UPDATE_DR:  state_nxt = tms ? TAP_SELECT_DR : TAP_IDLE;
            TAP_SELECT_IR:  state_nxt = tms ? TAP_RESET     : TAP_CAPTURE_IR; // Fifth TMS high
            TAP_CAPTURE_IR: state_nxt = tms ? TAP_EXIT1_IR  : TAP_SHIFT_IR;
            TAP_SHIFT_IR:   state_nxt = tms ? TAP_EXIT1_IR  : TAP_SHIFT_IR;
            TAP_EXIT1_IR:   state_nxt = tms ? TAP_UPDATE_IR : TAP_PAUSE_IR;
            TAP_PAUSE_IR:   state_nxt = tms ? TAP_EXIT2_IR  : TAP_PAUSE_IR;
            TAP_EXIT2_IR:   state_nxt = tms ? TAP_UPDATE_IR : TAP_SHIFT_IR;
            TAP_UPDATE_IR:  state_nxt = tms ? TAP_SELECT_DR : TAP_IDLE;
            default:        state_nxt = TAP_RESET;
        endcase
    end

    always_ff @(posedge tck) begin
        if (memi_rst) begin
            state <= TAP_RESET;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge tck) begin
        if (memi_rst) begin
            ir_sr <= '0;
            ir    <= `CDP_IR_JDPACC;                  // Default instruction
        end else begin
            case (state)
                TAP_RESET:      ir    <= `CDP_IR_JDPACC;
                TAP_CAPTURE_IR: ir_sr <= {{(`CDP_IR_WIDTH-1){1'b0}}, 1'b1}; // Fixed 0001
                TAP_SHIFT_IR:   ir_sr <= {tdi, ir_sr[`CDP_IR_WIDTH-1:1]};  // LSB first
                TAP_UPDATE_IR:  ir    <= ir_sr;
                default:        ;
            endcase
        end
    end

    // Chain select and state strobes
    always_comb begin
        ctl.sel_jdpacc  = (ir == `CDP_IR_JDPACC);
        ctl.sel_cdpacc  = (ir == `CDP_IR_CDPACC);
        ctl.capture_dr  = (state == TAP_CAPTURE_DR);
        ctl.shift_dr    = (state == TAP_SHIFT_DR);
        ctl.update_dr   = (state == TAP_UPDATE_DR);
        ctl.logic_reset = (state == TAP_RESET);
    end

    assign tdo = (state == TAP_SHIFT_IR) ? ir_sr[0] : dr_tdo; // IR or DR out

endmodule

// File: jtag_debug_bridge.f
+incdir+design
design/jtag_pkg.sv
design/cdp_pkg.sv
design/tap_ctrl.sv
design/cdp_scan_chain.sv
design/cdp_cmd_regs.sv
design/memi_master.sv
design/jtag_debug_bridge.sv
tb/tb_jtag_debug_bridge.sv

// File: tb/tb_jtag_debug_bridge.sv
`timescale 1ns/1ps
`include "cdp_defs.svh"

module tb_jtag_debug_bridge import cdp_pkg::*; ();

    localparam int      NR_SLAVES   = `CDP_NR_SLAVES;
    localparam int      NR_WORDS    = 1 << `CDP_ADDR_WIDTH;
    localparam int      START_LIMIT = 20;            // Cycles from Update-DR to sel
    localparam int      END_LIMIT   = 300;           // Covers the long ready wait
    localparam cdp_op_e OP_NONE     = cdp_op_e'(3'd7); // Ignored opcode, capture only

    logic                       tck;
    logic                       memi_rst;
    logic                       tms;
    logic                       tdi;
    logic                       tdo;
    memi_req_t                  memi_bus;
    logic                       memi_ready;
    logic [`CDP_DATA_WIDTH-1:0] memi_rdata;

    logic [31:0]                rng_state;
    int                         slave_delay;         // Ready delay of next transfer
    int                         wait_cnt;            // Cycles sel seen high
    logic [`CDP_DATA_WIDTH-1:0] slave_mem [NR_SLAVES][NR_WORDS];
    logic [`CDP_DATA_WIDTH-1:0] ref_mem   [NR_SLAVES][NR_WORDS];
    logic [`CDP_DATA_WIDTH-1:0] ref_select, ref_dtr, ref_result;
    logic [`CDP_ADDR_WIDTH-1:0] ref_taddr;
    cdp_ack_e                   ref_ack;

    always #4 tck = ~tck;                            // 8 ns period

    jtag_debug_bridge u_jtag_debug_bridge (
        .tck        (tck),
        .memi_rst   (memi_rst),
        .tms        (tms),
        .tdi        (tdi),
        .tdo        (tdo),
        .memi_bus   (memi_bus),
        .memi_ready (memi_ready),
        .memi_rdata (memi_rdata)
    );

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223; // LCG step
        return rng_state;
    endfunction

    function automatic logic [31:0] fill_word(input int s, input int a);
        return 32'h9e37_79b9 * ((s << `CDP_ADDR_WIDTH) | a) + 32'h1234_5678; // Slave and word
    endfunction

    function automatic int slave_index(input logic [NR_SLAVES-1:0] sel);
        int idx;
        idx = 0;
        for (int i = 0; i < NR_SLAVES; i++) begin
            if (sel[i]) idx = i;
        end
        return idx;
    endfunction

    // Slave memories, ready after slave_delay cycles of sel
    always @(posedge tck) begin
        if (memi_rst) begin
            memi_ready <= 1'b0;
            wait_cnt   <= 0;
            for (int s = 0; s < NR_SLAVES; s++) begin
                for (int a = 0; a < NR_WORDS; a++) begin
                    slave_mem[s][a] <= fill_word(s, a);
                end
            end
        end else if (memi_bus.sel != '0) begin
            memi_ready <= (wait_cnt >= slave_delay);
            wait_cnt   <= wait_cnt + 1;
            memi_rdata <= slave_mem[slave_index(memi_bus.sel)][memi_bus.addr];
            if (memi_ready && memi_bus.wr) begin             // Completing write cycle
                slave_mem[slave_index(memi_bus.sel)][memi_bus.addr] <= memi_bus.wdata;
            end
        end else begin
            memi_ready <= 1'b0;
            wait_cnt   <= 0;
        end
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_bus(input string name, input memi_req_t exp, input memi_req_t act);
        if (act !== exp) abort_run($sformatf("Mismatch %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_cap(input string name, input cdp_dr_u exp, input cdp_dr_u act);
        if (act !== exp) abort_run($sformatf("Mismatch %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_id(input string name, input logic [35:0] exp, input logic [35:0] act);
        if (act !== exp) abort_run($sformatf("Mismatch %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) abort_run($sformatf("Mismatch %s expected %h actual %h", name, exp, act));
    endtask

    // One TCK cycle, TDO sampled mid-cycle in the current state
    task automatic tap_step(input logic tms_v, input logic tdi_v, output logic tdo_v);
        @(posedge tck);
        tms <= tms_v;
        tdi <= tdi_v;
        @(negedge tck);
        tdo_v = tdo;
    endtask

    task automatic shift_ir(input logic [`CDP_IR_WIDTH-1:0] ir_v);
        logic bit_v;
        tap_step(1'b1, 1'b0, bit_v);                 // Select-DR
        tap_step(1'b1, 1'b0, bit_v);                 // Select-IR
        tap_step(1'b0, 1'b0, bit_v);                 // Capture-IR
        tap_step(1'b0, 1'b0, bit_v);                 // Shift-IR
        for (int i = 0; i < `CDP_IR_WIDTH; i++) begin
            tap_step(i == `CDP_IR_WIDTH - 1, ir_v[i], bit_v);
        end
        tap_step(1'b1, 1'b0, bit_v);                 // Update-IR
        tap_step(1'b0, 1'b0, bit_v);                 // Back to Idle
    endtask

    task automatic shift_dr(input logic [`CDP_DR_WIDTH-1:0] din,
                            output logic [`CDP_DR_WIDTH-1:0] dout);
        logic bit_v;
        tap_step(1'b1, 1'b0, bit_v);
        tap_step(1'b0, 1'b0, bit_v);                 // Capture-DR
        tap_step(1'b0, 1'b0, bit_v);
        for (int i = 0; i < `CDP_DR_WIDTH; i++) begin
            tap_step(i == `CDP_DR_WIDTH - 1, din[i], bit_v); // LSB first
            dout[i] = bit_v;
        end
        tap_step(1'b1, 1'b0, bit_v);                 // Update-DR
        tap_step(1'b0, 1'b0, bit_v);
    endtask

    // CDPACC scan, capture checked against the register model
    task automatic scan_cmd(input string name, input cdp_op_e op, input logic [31:0] data,
                            input logic wr, input logic exp_busy);
        cdp_dr_u word, got, exp;
        word.upd.data = data;
        word.upd.op   = op;
        word.upd.wr   = wr;
        shift_dr(word, got);
        exp.cap.result = ref_result;
        exp.cap.ack    = exp_busy ? ACK_BUSY : ref_ack;
        check_cap(name, exp, got);
        if (op == OP_SELECT) begin
            ref_select = data;
        end else if (op == OP_TADDR) begin
            ref_taddr = data[`CDP_ADDR_WIDTH-1:0];
        end else if (op == OP_DTR) begin
            ref_dtr = data;
            if (ref_select >= NR_SLAVES) ref_ack = ACK_NOSLAVE;
        end
    endtask

    task automatic wait_bus_start(input string name);
        int n;
        n = 0;
        while (memi_bus.sel == '0) begin
            if (n == START_LIMIT) abort_run($sformatf("Bus never started in %s", name));
            else begin
                @(negedge tck);
                n++;
            end
        end
    endtask

    task automatic wait_bus_end(input string name, input memi_req_t exp);
        int n;
        n = 0;
        while (memi_bus.sel != '0) begin
            check_bus(name, exp, memi_bus);          // Held stable until completion
            if (n == END_LIMIT) abort_run($sformatf("Bus never completed in %s", name));
            else begin
                @(negedge tck);
                n++;
            end
        end
        if (n < 2) abort_run($sformatf("Bus request held under two cycles in %s", name));
    endtask

    task automatic expect_bus_quiet(input string name, input int cycles);
        repeat (cycles) begin
            @(negedge tck);
            if (memi_bus.sel != '0) abort_run($sformatf("Unexpected bus transfer in %s", name));
        end
    endtask

    // DTR access through to completion, optional capture while busy
    task automatic run_transfer(input string name, input logic wr, input logic [31:0] data,
                                input logic probe);
        memi_req_t exp;
        int        s, a;
        s = ref_select;
        a = ref_taddr;
        scan_cmd(name, OP_DTR, data, wr, 1'b0);
        exp.sel    = '0;
        exp.sel[s] = 1'b1;
        exp.wr     = wr;
        exp.addr   = ref_taddr;
        exp.wdata  = ref_dtr;
        wait_bus_start(name);
        check_bus(name, exp, memi_bus);
        if (probe) scan_cmd({name, "_probe"}, OP_NONE, 32'd0, 1'b0, 1'b1);
        wait_bus_end(name, exp);
        if (wr) begin
            ref_mem[s][a] = data;
            check_word(name, ref_mem[s][a], slave_mem[s][a]);
        end else begin
            ref_result = ref_mem[s][a];
        end
        ref_ack = ACK_OK;
    endtask

    initial begin
        logic [`CDP_DR_WIDTH-1:0] id_v;
        logic [31:0]              rnd, data_v;
        logic                     wr_v, bit_v;
        tck        = 1'b0;
        rng_state  = 32'h8109_66d4;
        tms        <= 1'b1;
        tdi        <= 1'b0;
        memi_rst   <= 1'b1;
        memi_ready <= 1'b0;
        memi_rdata <= '0;
        slave_delay = 0;
        ref_select  = '0;
        ref_taddr   = '0;
        ref_dtr     = '0;
        ref_result  = '0;
        ref_ack     = ACK_OK;
        for (int s = 0; s < NR_SLAVES; s++) begin
            for (int a = 0; a < NR_WORDS; a++) ref_mem[s][a] = fill_word(s, a);
        end
        repeat (16) @(posedge tck);
        memi_rst <= 1'b0;
        tap_step(1'b0, 1'b0, bit_v);                 // Test-Logic-Reset to Idle

        shift_dr('0, id_v);                          // Reset IR selects JDPACC
        check_id("reset_id", `CDP_JDP_ID, id_v);
        shift_ir(`CDP_IR_CDPACC);

        for (int n = 0; n < 24; n++) begin           // Mixed random writes and reads
            rnd = next_random();
            scan_cmd("set_select", OP_SELECT, rnd >> 30, 1'b0, 1'b0);
            rnd = next_random();
            scan_cmd("set_taddr", OP_TADDR, rnd >> 27, 1'b0, 1'b0);
            rnd         = next_random();
            wr_v        = rnd[31];
            slave_delay = (rnd >> 16) % 7;
            data_v      = next_random();
            run_transfer(wr_v ? "rand_write" : "rand_read", wr_v, data_v, 1'b0);
            if (!wr_v) scan_cmd("read_capture", OP_NONE, 32'd0, 1'b0, 1'b0);
        end

        rnd = next_random();                         // Long ready wait
        scan_cmd("busy_select", OP_SELECT, rnd >> 30, 1'b0, 1'b0);
        scan_cmd("busy_taddr", OP_TADDR, rnd >> 27, 1'b0, 1'b0);
        slave_delay = 80;
        run_transfer("busy_read", 1'b0, next_random(), 1'b1);
        scan_cmd("busy_result", OP_NONE, 32'd0, 1'b0, 1'b0);
        slave_delay = 0;

        rnd = next_random();                         // SELECT beyond last slave
        scan_cmd("bad_select", OP_SELECT, 32'd4 + (rnd >> 20), 1'b0, 1'b0);
        scan_cmd("noslave_dtr", OP_DTR, next_random(), 1'b1, 1'b0);
        expect_bus_quiet("noslave_dtr", START_LIMIT);
        scan_cmd("noslave_capture", OP_NONE, 32'd0, 1'b0, 1'b0);

        // SELECT still invalid, so the pass through Update-DR starts nothing
        tap_step(1'b1, 1'b0, bit_v);
        tap_step(1'b0, 1'b0, bit_v);
        tap_step(1'b0, 1'b0, bit_v);                 // Into Shift-DR
        repeat (18) begin
            rnd = next_random();
            tap_step(1'b0, rnd[31], bit_v);
        end
        repeat (5) tap_step(1'b1, 1'b0, bit_v);      // Reaches Test-Logic-Reset
        expect_bus_quiet("tms_reset", START_LIMIT);
        tap_step(1'b0, 1'b0, bit_v);
        shift_dr('0, id_v);
        check_id("tms_reset_id", `CDP_JDP_ID, id_v);

        $display("Done: no errors");
        $finish;
    end

endmodule
